// ==== design/core_cfg_pkg.sv ====
`default_nettype none

package core_cfg_pkg;

   // Datapath word width
   localparam int XLEN = 32;

   // Register index width and register count
   localparam int REG_ADDR_W = 5;
   localparam int REG_COUNT  = 32;

   // Bit counter covers one word, LSB first
   localparam int CNT_W = 5;

   // Byte lanes on the data bus
   localparam int SEL_W = XLEN / 8;

endpackage

`default_nettype wire

// ==== design/rv_isa_pkg.sv ====
`default_nettype none

package rv_isa_pkg;

   // Field positions in the instruction word
   localparam int OPC_W  = 7;
   localparam int RD_LSB = 7;
   localparam int F3_LSB = 12;
   localparam int RS1_LSB = 15;
   localparam int RS2_LSB = 20;
   localparam int F7_LSB = 25;

   localparam logic [OPC_W-1:0] OPC_LUI    = 7'b0110111;
   localparam logic [OPC_W-1:0] OPC_OP_IMM = 7'b0010011;
   localparam logic [OPC_W-1:0] OPC_OP     = 7'b0110011;
   localparam logic [OPC_W-1:0] OPC_STORE  = 7'b0100011;

   localparam logic [2:0] F3_ADD = 3'b000;
   localparam logic [2:0] F3_XOR = 3'b100;
   localparam logic [2:0] F3_OR  = 3'b110;
   localparam logic [2:0] F3_AND = 3'b111;
   localparam logic [2:0] F3_SW  = 3'b010;

   // Bit within funct7 that turns ADD into SUB
   localparam int F7_SUB = 5;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_PASS_B
   } alu_op_t;

endpackage

`default_nettype wire

// ==== design/core_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module core_sequencer #(
   parameter logic [core_cfg_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  wire                             clk,
   input  wire                             i_reset,
   input  wire                             i_ibus_ack,
   input  wire                             i_dbus_ack,
   input  wire                             i_is_store,
   output logic                            o_ibus_cyc,
   output logic [core_cfg_pkg::XLEN-1:0]   o_ibus_adr,
   output logic                            o_dbus_cyc,
   output wire                             o_instr_latch,
   output logic [core_cfg_pkg::CNT_W-1:0]  o_cnt,
   output wire                             o_cnt_en,
   output wire                             o_cnt_done
);

   typedef enum logic [1:0] {
      PH_FETCH,
      PH_EXEC,
      PH_STORE
   } phase_t;

   phase_t phase;
   logic   retire;

   assign o_instr_latch = o_ibus_cyc & i_ibus_ack;
   assign o_cnt_en      = (phase == PH_EXEC);
   assign o_cnt_done    = o_cnt_en & (&o_cnt);

   // Instruction done at the last bit or after the store ack
   assign retire = (o_cnt_done & ~i_is_store) | (o_dbus_cyc & i_dbus_ack);

   always_ff @(posedge clk) begin
      if (i_reset) begin
         phase      <= PH_FETCH;
         o_ibus_cyc <= 1'b0;
         o_dbus_cyc <= 1'b0;
      end else begin
         case (phase)
            PH_FETCH: begin
               if (o_instr_latch) begin
                  o_ibus_cyc <= 1'b0;
                  phase      <= PH_EXEC;
               end else begin
                  o_ibus_cyc <= 1'b1;
               end
            end
            PH_EXEC: begin
               if (o_cnt_done) begin
                  if (i_is_store) begin
                     o_dbus_cyc <= 1'b1;
                     phase      <= PH_STORE;
                  end else begin
                     o_ibus_cyc <= 1'b1;
                     phase      <= PH_FETCH;
                  end
               end
            end
            PH_STORE: begin
               if (o_dbus_cyc && i_dbus_ack) begin
                  o_dbus_cyc <= 1'b0;
                  o_ibus_cyc <= 1'b1;
                  phase      <= PH_FETCH;
               end
            end
            default: phase <= PH_FETCH;
         endcase
      end
   end

   // Wraps back to zero after bit 31
   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_cnt <= '0;
      end else if (o_cnt_en) begin
         o_cnt <= o_cnt + 1'b1;
      end
   end

   always_ff @(posedge clk) begin
      if (i_reset) begin
         o_ibus_adr <= RESET_PC;
      end else if (retire) begin
         o_ibus_adr <= o_ibus_adr + core_cfg_pkg::XLEN'(4);
      end
   end

   assert property (@(posedge clk) disable iff (i_reset) !(o_ibus_cyc && o_dbus_cyc))
      else $error("instruction and data bus cycles overlap");

   // Counter rests at zero outside execute
   assert property (@(posedge clk) disable iff (i_reset) !o_cnt_en |-> (o_cnt == '0))
      else $error("bit counter moved outside the execute phase");

endmodule

`default_nettype wire

// ==== design/instr_decode.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decode (
   input  wire                                   clk,
   input  wire                                   i_reset,
   input  wire [core_cfg_pkg::XLEN-1:0]          i_ibus_rdt,
   input  wire                                   i_instr_latch,
   input  wire [core_cfg_pkg::CNT_W-1:0]         i_cnt,
   output wire [core_cfg_pkg::REG_ADDR_W-1:0]    o_rs1_addr,
   output wire [core_cfg_pkg::REG_ADDR_W-1:0]    o_rs2_addr,
   output wire [core_cfg_pkg::REG_ADDR_W-1:0]    o_rd_addr,
   output wire                                   o_rd_wen,
   output wire                                   o_op_b_imm,
   output rv_isa_pkg::alu_op_t                   o_alu_op,
   output wire                                   o_is_store,
   output wire                                   o_imm_bit
);

   logic [core_cfg_pkg::XLEN-1:0]       instr;
   logic [rv_isa_pkg::OPC_W-1:0]        opcode;
   logic [2:0]                          funct3;
   logic [6:0]                          funct7;
   logic                                is_lui;
   logic                                is_op_imm;
   logic                                is_op;
   logic                                f3_alu;
   logic                                op_ok;
   logic [core_cfg_pkg::XLEN-1:0]       imm_i;
   logic [core_cfg_pkg::XLEN-1:0]       imm_s;
   logic [core_cfg_pkg::XLEN-1:0]       imm_u;
   logic [core_cfg_pkg::XLEN-1:0]       imm_word;

   // Cleared word decodes as a no-op
   always_ff @(posedge clk) begin
      if (i_reset) begin
         instr <= '0;
      end else if (i_instr_latch) begin
         instr <= i_ibus_rdt;
      end
   end

   assign opcode = instr[rv_isa_pkg::OPC_W-1:0];
   assign funct3 = instr[rv_isa_pkg::F3_LSB +: 3];
   assign funct7 = instr[rv_isa_pkg::F7_LSB +: 7];

   assign o_rd_addr  = instr[rv_isa_pkg::RD_LSB +: core_cfg_pkg::REG_ADDR_W];
   assign o_rs1_addr = instr[rv_isa_pkg::RS1_LSB +: core_cfg_pkg::REG_ADDR_W];
   assign o_rs2_addr = instr[rv_isa_pkg::RS2_LSB +: core_cfg_pkg::REG_ADDR_W];

   assign is_lui    = (opcode == rv_isa_pkg::OPC_LUI);
   assign is_op_imm = (opcode == rv_isa_pkg::OPC_OP_IMM);
   assign is_op     = (opcode == rv_isa_pkg::OPC_OP);

   assign f3_alu = (funct3 == rv_isa_pkg::F3_ADD) | (funct3 == rv_isa_pkg::F3_XOR) |
                   (funct3 == rv_isa_pkg::F3_OR)  | (funct3 == rv_isa_pkg::F3_AND);

   // Register ops: funct7 zero, except the SUB bit on ADD
   assign op_ok = is_op & f3_alu &
                  ((funct7 & ~(7'd1 << rv_isa_pkg::F7_SUB)) == 7'd0) &
                  (~funct7[rv_isa_pkg::F7_SUB] | (funct3 == rv_isa_pkg::F3_ADD));

   assign o_rd_wen   = (is_lui | op_ok | (is_op_imm & f3_alu)) & (o_rd_addr != '0);
   assign o_op_b_imm = ~is_op;
   assign o_is_store = (opcode == rv_isa_pkg::OPC_STORE) & (funct3 == rv_isa_pkg::F3_SW);

   always_comb begin
      case (funct3)
         rv_isa_pkg::F3_XOR: o_alu_op = rv_isa_pkg::ALU_XOR;
         rv_isa_pkg::F3_OR:  o_alu_op = rv_isa_pkg::ALU_OR;
         rv_isa_pkg::F3_AND: o_alu_op = rv_isa_pkg::ALU_AND;
         default: begin
            if (is_op && funct7[rv_isa_pkg::F7_SUB]) begin
               o_alu_op = rv_isa_pkg::ALU_SUB;
            end else begin
               o_alu_op = rv_isa_pkg::ALU_ADD;
            end
         end
      endcase
      if (is_lui) begin
         o_alu_op = rv_isa_pkg::ALU_PASS_B;
      end
   end

   assign imm_i = {{20{instr[31]}}, instr[31:20]};
   assign imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
   assign imm_u = {instr[31:12], 12'b0};

   always_comb begin
      if (is_lui) begin
         imm_word = imm_u;
      end else if (opcode == rv_isa_pkg::OPC_STORE) begin
         imm_word = imm_s;
      end else begin
         imm_word = imm_i;
      end
   end

   assign o_imm_bit = imm_word[i_cnt];

endmodule

`default_nettype wire

// ==== design/serial_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_regfile (
   input  wire                                clk,
   input  wire [core_cfg_pkg::CNT_W-1:0]      i_cnt,
   input  wire                                i_cnt_en,
   input  wire [core_cfg_pkg::REG_ADDR_W-1:0] i_rs1_addr,
   input  wire [core_cfg_pkg::REG_ADDR_W-1:0] i_rs2_addr,
   input  wire [core_cfg_pkg::REG_ADDR_W-1:0] i_rd_addr,
   input  wire                                i_rd_wen,
   input  wire                                i_rd_bit,
   output wire                                o_rs1_bit,
   output wire                                o_rs2_bit
);

   logic [core_cfg_pkg::XLEN-1:0] regs [core_cfg_pkg::REG_COUNT];

   // Power-up contents are zero
   initial begin
      for (int i = 0; i < core_cfg_pkg::REG_COUNT; i++) begin
         regs[i] = '0;
      end
   end

   // Bit n is read now and written at the edge
   assign o_rs1_bit = regs[i_rs1_addr][i_cnt];
   assign o_rs2_bit = regs[i_rs2_addr][i_cnt];

   always_ff @(posedge clk) begin
      if (i_cnt_en && i_rd_wen) begin
         regs[i_rd_addr][i_cnt] <= i_rd_bit;
      end
   end

   // x0 relies on the write mask in decode
   assert property (@(posedge clk) regs[0] == '0)
      else $error("register x0 was written");

endmodule

`default_nettype wire

// ==== design/serial_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_alu (
   input  wire                            clk,
   input  wire                            i_reset,
   input  wire                            i_cnt_en,
   input  wire [core_cfg_pkg::CNT_W-1:0]  i_cnt,
   input  wire rv_isa_pkg::alu_op_t       i_alu_op,
   input  wire                            i_op_b_imm,
   input  wire                            i_rs1_bit,
   input  wire                            i_rs2_bit,
   input  wire                            i_imm_bit,
   output logic                           o_rd_bit
);

   logic op_b;
   logic sub;
   logic b_add;
   logic carry_in;
   logic carry_r;
   logic sum;

   assign op_b  = i_op_b_imm ? i_imm_bit : i_rs2_bit;
   assign sub   = (i_alu_op == rv_isa_pkg::ALU_SUB);
   assign b_add = op_b ^ sub;

   // Subtract as rs1 + ~b + 1
   assign carry_in = (i_cnt == '0) ? sub : carry_r;
   assign sum      = i_rs1_bit ^ b_add ^ carry_in;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry_r <= 1'b0;
      end else if (i_cnt_en) begin
         carry_r <= (i_rs1_bit & b_add) | (carry_in & (i_rs1_bit ^ b_add));
      end
   end

   always_comb begin
      case (i_alu_op)
         rv_isa_pkg::ALU_ADD,
         rv_isa_pkg::ALU_SUB:    o_rd_bit = sum;
         rv_isa_pkg::ALU_AND:    o_rd_bit = i_rs1_bit & op_b;
         rv_isa_pkg::ALU_OR:     o_rd_bit = i_rs1_bit | op_b;
         rv_isa_pkg::ALU_XOR:    o_rd_bit = i_rs1_bit ^ op_b;
         rv_isa_pkg::ALU_PASS_B: o_rd_bit = op_b;
         default:                o_rd_bit = 1'b0;
      endcase
   end

endmodule

`default_nettype wire

// ==== design/store_bufreg.sv ====
`timescale 1ns/1ps
`default_nettype none

module store_bufreg (
   input  wire                            clk,
   input  wire                            i_reset,
   input  wire                            i_cnt_en,
   input  wire [core_cfg_pkg::CNT_W-1:0]  i_cnt,
   input  wire                            i_rs1_bit,
   input  wire                            i_imm_bit,
   input  wire                            i_rs2_bit,
   output logic [core_cfg_pkg::XLEN-1:0]  o_dbus_adr,
   output logic [core_cfg_pkg::XLEN-1:0]  o_dbus_dat
);

   logic carry_r;
   logic carry_in;
   logic adr_bit;

   // Effective address rs1 + imm, one bit per cycle
   assign carry_in = (i_cnt == '0) ? 1'b0 : carry_r;
   assign adr_bit  = i_rs1_bit ^ i_imm_bit ^ carry_in;

   always_ff @(posedge clk) begin
      if (i_reset) begin
         carry_r <= 1'b0;
      end else if (i_cnt_en) begin
         carry_r <= (i_rs1_bit & i_imm_bit) | (carry_in & (i_rs1_bit ^ i_imm_bit));
      end
   end

   // LSB enters first and ends up in bit 0 after 32 shifts
   always_ff @(posedge clk) begin
      if (i_cnt_en) begin
         o_dbus_adr <= {adr_bit, o_dbus_adr[core_cfg_pkg::XLEN-1:1]};
         o_dbus_dat <= {i_rs2_bit, o_dbus_dat[core_cfg_pkg::XLEN-1:1]};
      end
   end

endmodule

`default_nettype wire

// ==== design/serial_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module serial_core_top #(
   parameter logic [core_cfg_pkg::XLEN-1:0] RESET_PC = '0
) (
   input  wire                              clk,
   input  wire                              i_reset,
   // Instruction bus
   output wire [core_cfg_pkg::XLEN-1:0]     o_ibus_adr,
   output wire                              o_ibus_cyc,
   input  wire [core_cfg_pkg::XLEN-1:0]     i_ibus_rdt,
   input  wire                              i_ibus_ack,
   // Data bus
   output wire [core_cfg_pkg::XLEN-1:0]     o_dbus_adr,
   output wire [core_cfg_pkg::XLEN-1:0]     o_dbus_dat,
   output wire [core_cfg_pkg::SEL_W-1:0]    o_dbus_sel,
   output wire                              o_dbus_we,
   output wire                              o_dbus_cyc,
   input  wire                              i_dbus_ack
);

   wire [core_cfg_pkg::CNT_W-1:0]      cnt;
   wire                                cnt_en;
   wire                                instr_latch;
   wire [core_cfg_pkg::REG_ADDR_W-1:0] rs1_addr;
   wire [core_cfg_pkg::REG_ADDR_W-1:0] rs2_addr;
   wire [core_cfg_pkg::REG_ADDR_W-1:0] rd_addr;
   wire                                rd_wen;
   wire                                op_b_imm;
   rv_isa_pkg::alu_op_t                alu_op;
   wire                                is_store;
   wire                                imm_bit;
   wire                                rs1_bit;
   wire                                rs2_bit;
   wire                                rd_bit;

   // Word stores only
   assign o_dbus_sel = '1;
   assign o_dbus_we  = 1'b1;

   core_sequencer #(
      .RESET_PC (RESET_PC)
   ) sequencer (
      .clk           (clk          ),
      .i_reset       (i_reset      ),
      .i_ibus_ack    (i_ibus_ack   ),
      .i_dbus_ack    (i_dbus_ack   ),
      .i_is_store    (is_store     ),
      .o_ibus_cyc    (o_ibus_cyc   ),
      .o_ibus_adr    (o_ibus_adr   ),
      .o_dbus_cyc    (o_dbus_cyc   ),
      .o_instr_latch (instr_latch  ),
      .o_cnt         (cnt          ),
      .o_cnt_en      (cnt_en       ),
      .o_cnt_done    ()
   );

   instr_decode decode (
      .clk           (clk          ),
      .i_reset       (i_reset      ),
      .i_ibus_rdt    (i_ibus_rdt   ),
      .i_instr_latch (instr_latch  ),
      .i_cnt         (cnt          ),
      .o_rs1_addr    (rs1_addr     ),
      .o_rs2_addr    (rs2_addr     ),
      .o_rd_addr     (rd_addr      ),
      .o_rd_wen      (rd_wen       ),
      .o_op_b_imm    (op_b_imm     ),
      .o_alu_op      (alu_op       ),
      .o_is_store    (is_store     ),
      .o_imm_bit     (imm_bit      )
   );

   serial_regfile regfile (
      .clk        (clk       ),
      .i_cnt      (cnt       ),
      .i_cnt_en   (cnt_en    ),
      .i_rs1_addr (rs1_addr  ),
      .i_rs2_addr (rs2_addr  ),
      .i_rd_addr  (rd_addr   ),
      .i_rd_wen   (rd_wen    ),
      .i_rd_bit   (rd_bit    ),
      .o_rs1_bit  (rs1_bit   ),
      .o_rs2_bit  (rs2_bit   )
   );

   serial_alu alu (
      .clk        (clk       ),
      .i_reset    (i_reset   ),
      .i_cnt_en   (cnt_en    ),
      .i_cnt      (cnt       ),
      .i_alu_op   (alu_op    ),
      .i_op_b_imm (op_b_imm  ),
      .i_rs1_bit  (rs1_bit   ),
      .i_rs2_bit  (rs2_bit   ),
      .i_imm_bit  (imm_bit   ),
      .o_rd_bit   (rd_bit    )
   );

   store_bufreg bufreg (
      .clk        (clk       ),
      .i_reset    (i_reset   ),
      .i_cnt_en   (cnt_en    ),
      .i_cnt      (cnt       ),
      .i_rs1_bit  (rs1_bit   ),
      .i_imm_bit  (imm_bit   ),
      .i_rs2_bit  (rs2_bit   ),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat)
   );

endmodule

`default_nettype wire

// ==== dv/tb_serial_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_serial_core;

   localparam int XLEN = core_cfg_pkg::XLEN;
   localparam int NREGS = core_cfg_pkg::REG_COUNT;
   localparam logic [XLEN-1:0] RESET_PC = 32'h0000_0200;
   localparam int RAND_LEN = 60;
   localparam int PROG_LEN = RAND_LEN + NREGS;
   localparam logic [11:0] STORE_BASE = 12'h400;
   localparam logic [6:0] F7_SUB_CODE = 7'b0100000;
   localparam int FETCH_TIMEOUT = 200;
   localparam int STORE_TIMEOUT = 20000;
   localparam int RUN_TIMEOUT = 100000;

   logic clk = 1'b0;
   logic i_reset;
   logic [XLEN-1:0] i_ibus_rdt;
   logic i_ibus_ack;
   logic i_dbus_ack;
   wire [XLEN-1:0] o_ibus_adr;
   wire o_ibus_cyc;
   wire [XLEN-1:0] o_dbus_adr;
   wire [XLEN-1:0] o_dbus_dat;
   wire [core_cfg_pkg::SEL_W-1:0] o_dbus_sel;
   wire o_dbus_we;
   wire o_dbus_cyc;

   logic [31:0] prog [PROG_LEN];
   logic [31:0] model_regs [NREGS];
   logic [31:0] exp_adr_q [$];
   logic [31:0] exp_dat_q [$];
   logic [15:0] lfsr_state;
   int total_stores = 0;
   int stores_done = 0;

   serial_core_top #(
      .RESET_PC (RESET_PC)
   ) DUT (
      .clk        (clk       ),
      .i_reset    (i_reset   ),
      .o_ibus_adr (o_ibus_adr),
      .o_ibus_cyc (o_ibus_cyc),
      .i_ibus_rdt (i_ibus_rdt),
      .i_ibus_ack (i_ibus_ack),
      .o_dbus_adr (o_dbus_adr),
      .o_dbus_dat (o_dbus_dat),
      .o_dbus_sel (o_dbus_sel),
      .o_dbus_we  (o_dbus_we ),
      .o_dbus_cyc (o_dbus_cyc),
      .i_dbus_ack (i_dbus_ack)
   );

   always #2 clk = ~clk;

   task automatic abort_run(input string reason);
      $display("%s", reason);
      $display("TEST FAIL");
      $fatal(1, "simulation stopped on the first error");
   endtask

   task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                              input string what);
      if (got !== exp) begin
         abort_run($sformatf("CHECK FAILED at %0t ns: %s, got %08h expected %08h",
                             $time, what, got, exp));
      end
   endtask

   // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
   function automatic logic [31:0] rand_bits(input int nbits);
      logic [31:0] value;
      value = '0;
      for (int i = 0; i < nbits; i++) begin
         value = {value[30:0], lfsr_state[0]};
         if (lfsr_state[0]) begin
            lfsr_state = (lfsr_state >> 1) ^ 16'hB400;
         end else begin
            lfsr_state = lfsr_state >> 1;
         end
      end
      return value;
   endfunction

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd);
      return {f7, rs2, rs1, f3, rd, rv_isa_pkg::OPC_OP};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd);
      return {imm, rs1, f3, rd, rv_isa_pkg::OPC_OP_IMM};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1);
      return {imm[11:5], rs2, rs1, rv_isa_pkg::F3_SW, imm[4:0], rv_isa_pkg::OPC_STORE};
   endfunction

   function automatic logic [31:0] random_instr();
      logic [3:0] kind;
      logic [4:0] rd;
      logic [4:0] rs1;
      logic [4:0] rs2;
      logic [11:0] imm;
      logic [31:0] word;
      kind = 4'(rand_bits(4));
      rd = 5'(rand_bits(5));
      rs1 = 5'(rand_bits(5));
      rs2 = 5'(rand_bits(5));
      imm = 12'(rand_bits(12));
      case (kind)
         4'd0, 4'd1: word = {20'(rand_bits(20)), rd, rv_isa_pkg::OPC_LUI};
         4'd2, 4'd3: word = enc_i(imm, rs1, rv_isa_pkg::F3_ADD, rd);
         4'd4: word = enc_i(imm, rs1, rv_isa_pkg::F3_AND, rd);
         4'd5: word = enc_i(imm, rs1, rv_isa_pkg::F3_OR, rd);
         4'd6: word = enc_i(imm, rs1, rv_isa_pkg::F3_XOR, rd);
         4'd7: word = enc_r(7'd0, rs2, rs1, rv_isa_pkg::F3_ADD, rd);
         4'd8: word = enc_r(F7_SUB_CODE, rs2, rs1, rv_isa_pkg::F3_ADD, rd);
         4'd9: word = enc_r(7'd0, rs2, rs1, rv_isa_pkg::F3_AND, rd);
         4'd10: word = enc_r(7'd0, rs2, rs1, rv_isa_pkg::F3_OR, rd);
         4'd11: word = enc_r(7'd0, rs2, rs1, rv_isa_pkg::F3_XOR, rd);
         4'd12, 4'd13: word = enc_s(imm, rs2, rs1);
         // Branch encoding acts as a no-op here
         4'd14: word = {25'(rand_bits(25)), 7'b1100011};
         default: word = enc_r(F7_SUB_CODE, rs2, rs1, rv_isa_pkg::F3_XOR, rd);
      endcase
      return word;
   endfunction

   task automatic build_program();
      for (int i = 0; i < RAND_LEN; i++) begin
         prog[i] = random_instr();
      end
      // Dump of every register including x0
      for (int r = 0; r < NREGS; r++) begin
         prog[RAND_LEN + r] = enc_s(STORE_BASE + 12'(4 * r), 5'(r), 5'd0);
      end
      for (int i = 0; i < PROG_LEN; i++) begin
         if (prog[i][6:0] == rv_isa_pkg::OPC_STORE && prog[i][14:12] == rv_isa_pkg::F3_SW) begin
            total_stores++;
         end
      end
   endtask

   // Executes one word on model_regs and returns 1 for a store
   function automatic logic ref_execute(input logic [31:0] instr,
                                        output logic [31:0] st_adr,
                                        output logic [31:0] st_dat);
      logic [2:0] f3;
      logic [6:0] f7;
      logic [4:0] rd;
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] imm_i;
      logic [31:0] res;
      logic wen;
      logic is_st;
      f3 = instr[14:12];
      f7 = instr[31:25];
      rd = instr[11:7];
      a = model_regs[instr[19:15]];
      b = model_regs[instr[24:20]];
      imm_i = {{20{instr[31]}}, instr[31:20]};
      res = '0;
      wen = 1'b0;
      is_st = 1'b0;
      st_adr = '0;
      st_dat = '0;
      case (instr[6:0])
         rv_isa_pkg::OPC_LUI: begin
            res = {instr[31:12], 12'b0};
            wen = 1'b1;
         end
         rv_isa_pkg::OPC_OP_IMM: begin
            wen = 1'b1;
            case (f3)
               rv_isa_pkg::F3_ADD: res = a + imm_i;
               rv_isa_pkg::F3_XOR: res = a ^ imm_i;
               rv_isa_pkg::F3_OR:  res = a | imm_i;
               rv_isa_pkg::F3_AND: res = a & imm_i;
               default: wen = 1'b0;
            endcase
         end
         rv_isa_pkg::OPC_OP: begin
            wen = 1'b1;
            if (f7 == F7_SUB_CODE && f3 == rv_isa_pkg::F3_ADD) begin
               res = a - b;
            end else if (f7 != 7'd0) begin
               wen = 1'b0;
            end else begin
               case (f3)
                  rv_isa_pkg::F3_ADD: res = a + b;
                  rv_isa_pkg::F3_XOR: res = a ^ b;
                  rv_isa_pkg::F3_OR:  res = a | b;
                  rv_isa_pkg::F3_AND: res = a & b;
                  default: wen = 1'b0;
               endcase
            end
         end
         rv_isa_pkg::OPC_STORE: begin
            if (f3 == rv_isa_pkg::F3_SW) begin
               is_st = 1'b1;
               st_adr = a + {{20{instr[31]}}, instr[31:25], instr[11:7]};
               st_dat = b;
            end
         end
         default: begin
         end
      endcase
      if (wen && rd != 5'd0) begin
         model_regs[rd] = res;
      end
      return is_st;
   endfunction

   initial begin : ibus_model
      int wait_cnt;
      int delay;
      int idx;
      logic is_st;
      logic [31:0] exp_pc;
      logic [31:0] word;
      logic [31:0] st_adr;
      logic [31:0] st_dat;
      i_ibus_ack = 1'b0;
      i_ibus_rdt = '0;
      exp_pc = RESET_PC;
      forever begin
         @(posedge clk);
         #1;
         i_ibus_ack = 1'b0;
         wait_cnt = 0;
         while (o_ibus_cyc !== 1'b1) begin
            wait_cnt++;
            if (wait_cnt > FETCH_TIMEOUT) begin
               abort_run("Timeout: the core stopped fetching instructions");
            end
            @(posedge clk);
            #1;
         end
         check_equal(o_ibus_adr, exp_pc, "fetch address");
         delay = int'(rand_bits(3));
         for (int d = 0; d < delay; d++) begin
            @(posedge clk);
            #1;
            check_equal(32'(o_ibus_cyc), 32'd1, "fetch cyc held without ack");
            check_equal(o_ibus_adr, exp_pc, "fetch address held without ack");
         end
         idx = int'((o_ibus_adr - RESET_PC) >> 2);
         word = (idx >= 0 && idx < PROG_LEN) ? prog[idx] : 32'd0;
         i_ibus_rdt = word;
         i_ibus_ack = 1'b1;
         is_st = ref_execute(word, st_adr, st_dat);
         if (is_st) begin
            exp_adr_q.push_back(st_adr);
            exp_dat_q.push_back(st_dat);
         end
         exp_pc = exp_pc + 32'd4;
      end
   end

   initial begin : dbus_compare
      int wait_cnt;
      int delay;
      logic [31:0] exp_adr;
      logic [31:0] exp_dat;
      i_dbus_ack = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         if (i_dbus_ack) begin
            stores_done++;
         end
         i_dbus_ack = 1'b0;
         wait_cnt = 0;
         while (o_dbus_cyc !== 1'b1) begin
            wait_cnt++;
            if (wait_cnt > STORE_TIMEOUT) begin
               abort_run("Timeout: no data bus transfer came for a long time");
            end
            @(posedge clk);
            #1;
         end
         check_equal(32'(exp_adr_q.size()), 32'd1, "pending stores at a data transfer");
         exp_adr = exp_adr_q.pop_front();
         exp_dat = exp_dat_q.pop_front();
         delay = int'(rand_bits(3));
         for (int d = 0; d < delay; d++) begin
            @(posedge clk);
            #1;
            check_equal(32'(o_dbus_cyc), 32'd1, "store cyc held without ack");
         end
         check_equal(o_dbus_adr, exp_adr, "store address");
         check_equal(o_dbus_dat, exp_dat, "store data");
         check_equal(32'(o_dbus_sel), 32'hF, "store byte select");
         check_equal(32'(o_dbus_we), 32'd1, "store write enable");
         i_dbus_ack = 1'b1;
      end
   end

   always @(negedge clk) begin
      if (i_reset === 1'b0) begin
         check_equal(32'(o_ibus_cyc & o_dbus_cyc), 32'd0, "ibus and dbus cyc overlap");
      end
   end

   initial begin : main_seq
      int wait_cnt;
      i_reset = 1'b1;
      lfsr_state = 16'd41618;
      for (int r = 0; r < NREGS; r++) begin
         model_regs[r] = '0;
      end
      build_program();
      for (int c = 0; c < 10; c++) begin
         @(posedge clk);
         #1;
         check_equal(32'(o_ibus_cyc), 32'd0, "ibus cyc in reset");
         check_equal(32'(o_dbus_cyc), 32'd0, "dbus cyc in reset");
      end
      i_reset = 1'b0;
      wait_cnt = 0;
      while (stores_done < total_stores) begin
         wait_cnt++;
         if (wait_cnt > RUN_TIMEOUT) begin
            abort_run("Timeout: the program did not finish all of its stores");
         end
         @(posedge clk);
         #1;
      end
      $display("TEST PASS");
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
design/core_cfg_pkg.sv
design/rv_isa_pkg.sv
design/core_sequencer.sv
design/instr_decode.sv
design/serial_regfile.sv
design/serial_alu.sv
design/store_bufreg.sv
design/serial_core_top.sv
dv/tb_serial_core.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_serial_core
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
SIM_BIN   ?= V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

# A $fatal in the testbench makes the binary exit with a failing status
sim:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -o $(SIM_BIN)
	./$(BUILD_DIR)/$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
